//--- src/cla_cfg_pkg.sv
package cla_cfg_pkg;

	// operand width in bits.
	localparam int width = 24;

	// one prefix level per power of two below width.
	localparam int prefix_levels = 5;

	// prefix levels plus the registered sum stage.
	localparam int latency = prefix_levels + 1;

	// bit 1 is the lsb.
	typedef logic [width:1] operand_t;

endpackage

//--- src/prefix_pkg.sv
package prefix_pkg;

	// generate in bit 0 and propagate in bit 1.
	typedef struct packed {
		logic p; // a | b or the group propagate.
		logic g; // a & b or the group generate.
	} pg_t;

	// one pair per operand bit with the lsb at position 1.
	typedef pg_t [cla_cfg_pkg::width:1] pg_vec_t;

endpackage

//--- src/prefix_stage.sv
module prefix_stage #(
	parameter int distance = 1
) (
	input  logic                clock,
	input  logic                rst_n,
	input  prefix_pkg::pg_vec_t pg_in,
	output prefix_pkg::pg_vec_t pg_out
);

	prefix_pkg::pg_vec_t pg_next;

	if (distance < 1 || distance >= cla_cfg_pkg::width) begin : g_bad_distance
		$error("prefix_stage distance %0d out of range", distance);
	end

	// positions above distance merge with the group just below them.
	for (genvar i = 1; i <= cla_cfg_pkg::width; i++) begin : g_pos
		if (i > distance) begin : g_merge
			assign pg_next[i].g = pg_in[i].g | (pg_in[i].p & pg_in[i - distance].g);
			assign pg_next[i].p = pg_in[i].p & pg_in[i - distance].p;
		end else begin : g_pass
			// already final at this level.
			assign pg_next[i] = pg_in[i];
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pg_out <= '0;
		end else begin
			pg_out <= pg_next;
		end
	end

endmodule

//--- src/prefix_network.sv
module prefix_network (
	input  logic                  clock,
	input  logic                  rst_n,
	input  cla_cfg_pkg::operand_t a,
	input  cla_cfg_pkg::operand_t b,
	output prefix_pkg::pg_vec_t   carries
);

	prefix_pkg::pg_vec_t seed;
	prefix_pkg::pg_vec_t level [cla_cfg_pkg::prefix_levels + 1];

	// the widest span has to reach the top bit.
	if ((1 << cla_cfg_pkg::prefix_levels) < cla_cfg_pkg::width) begin : g_short_tree
		$error("prefix_network needs more levels for width %0d", cla_cfg_pkg::width);
	end

	// bit pairs straight from the operands.
	// every position is seeded with its own generate, including bit 1.
	for (genvar i = 1; i <= cla_cfg_pkg::width; i++) begin : g_seed
		assign seed[i].g = a[i] & b[i];
		assign seed[i].p = a[i] | b[i];
	end

	assign level[0] = seed; // no input register.

	// kogge-stone chain over distances 1 2 4 8 16.
	for (genvar k = 0; k < cla_cfg_pkg::prefix_levels; k++) begin : g_level
		prefix_stage #(
			.distance(1 << k)
		) u_stage (
			.clock (clock),
			.rst_n (rst_n),
			.pg_in (level[k]),
			.pg_out(level[k + 1])
		);
	end

	// g of each position is now the carry out of that position.
	assign carries = level[cla_cfg_pkg::prefix_levels];

endmodule

//--- src/operand_delay.sv
module operand_delay #(
	parameter int depth = 5
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  cla_cfg_pkg::operand_t a,
	input  cla_cfg_pkg::operand_t b,
	input  logic                  in_valid,
	output cla_cfg_pkg::operand_t a_dly,
	output cla_cfg_pkg::operand_t b_dly,
	output logic                  valid_dly
);

	if (depth == 0) begin : g_direct
		assign a_dly     = a;
		assign b_dly     = b;
		assign valid_dly = in_valid;
	end else begin : g_line
		cla_cfg_pkg::operand_t a_q [depth];
		cla_cfg_pkg::operand_t b_q [depth];
		logic [depth-1:0]      valid_q;

		// operands shift every cycle.
		always_ff @(posedge clock) begin
			a_q[0] <= a;
			b_q[0] <= b;
			for (int i = 1; i < depth; i++) begin
				a_q[i] <= a_q[i - 1];
				b_q[i] <= b_q[i - 1];
			end
		end

		// strobe rides alongside the operands.
		always_ff @(posedge clock or negedge rst_n) begin
			if (!rst_n) begin
				valid_q <= '0;
			end else begin
				valid_q[0] <= in_valid;
				for (int i = 1; i < depth; i++) begin
					valid_q[i] <= valid_q[i - 1];
				end
			end
		end

		assign a_dly     = a_q[depth - 1];
		assign b_dly     = b_q[depth - 1];
		assign valid_dly = valid_q[depth - 1]; // oldest entry.
	end

endmodule

//--- src/sum_stage.sv
module sum_stage (
	input  logic                  clock,
	input  logic                  rst_n,
	input  cla_cfg_pkg::operand_t a_dly,
	input  cla_cfg_pkg::operand_t b_dly,
	input  prefix_pkg::pg_vec_t   carries,
	input  logic                  valid_dly,
	output cla_cfg_pkg::operand_t sum,
	output logic                  cout,
	output logic                  out_valid
);

	cla_cfg_pkg::operand_t sum_next;

	// half sum plus the carry out of the bit below.
	always_comb begin
		sum_next[1] = a_dly[1] ^ b_dly[1]; // carry-in is 0.
		for (int i = 2; i <= cla_cfg_pkg::width; i++) begin
			sum_next[i] = a_dly[i] ^ b_dly[i] ^ carries[i - 1].g;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			sum       <= '0;
			cout      <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			sum       <= sum_next;
			cout      <= carries[cla_cfg_pkg::width].g; // top carry.
			out_valid <= valid_dly;
		end
	end

endmodule

//--- src/cla_adder.sv
module cla_adder (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  cla_cfg_pkg::operand_t a,
	input  cla_cfg_pkg::operand_t b,
	output cla_cfg_pkg::operand_t sum,
	output logic                  cout,
	output logic                  out_valid
);

	prefix_pkg::pg_vec_t   carries;
	cla_cfg_pkg::operand_t a_dly;
	cla_cfg_pkg::operand_t b_dly;
	logic                  valid_dly;

	// carries ready five edges after the operands.
	prefix_network u_prefix (
		.clock  (clock),
		.rst_n  (rst_n),
		.a      (a),
		.b      (b),
		.carries(carries)
	);

	// raw operands and strobe held back to meet the carries.
	operand_delay #(
		.depth(cla_cfg_pkg::prefix_levels)
	) u_delay (
		.clock    (clock),
		.rst_n    (rst_n),
		.a        (a),
		.b        (b),
		.in_valid (in_valid),
		.a_dly    (a_dly),
		.b_dly    (b_dly),
		.valid_dly(valid_dly)
	);

	// one more edge for the sum.
	sum_stage u_sum (
		.clock    (clock),
		.rst_n    (rst_n),
		.a_dly    (a_dly),
		.b_dly    (b_dly),
		.carries  (carries),
		.valid_dly(valid_dly),
		.sum      (sum),
		.cout     (cout),
		.out_valid(out_valid)
	);

endmodule

//--- verification/cla_adder_checker.sv
module cla_adder_checker (
	input logic clock,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid
);

	// every strobe comes out exactly latency edges later.
	valid_follows_strobe: assert property (
		@(posedge clock) disable iff (!rst_n)
		out_valid == $past(in_valid, cla_cfg_pkg::latency)
	) else $error("out_valid differs from in_valid delayed by %0d cycles",
		cla_cfg_pkg::latency);

	reset_clears_valid: assert property (
		@(posedge clock) !rst_n |-> !out_valid
	) else $error("out_valid high while reset is asserted");

	// pipeline still empty right after reset.
	quiet_after_reset: assert property (
		@(posedge clock) $rose(rst_n) |-> !out_valid [*cla_cfg_pkg::latency]
	) else $error("out_valid high in the first %0d cycles after reset",
		cla_cfg_pkg::latency);

endmodule

bind cla_adder cla_adder_checker u_checker (
	.clock    (clock),
	.rst_n    (rst_n),
	.in_valid (in_valid),
	.out_valid(out_valid)
);

//--- verification/cla_adder_tb.sv
module cla_adder_tb;

	localparam int reset_cycles = 8;

	typedef struct {
		cla_cfg_pkg::operand_t a;
		cla_cfg_pkg::operand_t b;
		cla_cfg_pkg::operand_t sum;
		logic                  cout;
		logic                  gap;
		int                    line_no;
	} trace_entry_t;

	typedef struct {
		cla_cfg_pkg::operand_t sum;
		logic                  cout;
		string                 name;
	} expect_t;

	logic                  clock;
	logic                  rst_n;
	logic                  in_valid;
	cla_cfg_pkg::operand_t a;
	cla_cfg_pkg::operand_t b;
	cla_cfg_pkg::operand_t sum;
	logic                  cout;
	logic                  out_valid;

	trace_entry_t trace_q[$];
	expect_t      expected_q[$];
	logic [31:0]  lfsr_state;
	int           cycle_count;
	int           cycle_limit;

	cla_adder dut_i (
		.clock    (clock),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.sum      (sum),
		.cout     (cout),
		.out_valid(out_valid)
	);

	always #4 clock = ~clock;

	// taps 32 22 2 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_sum(input string name, input cla_cfg_pkg::operand_t expected,
			input cla_cfg_pkg::operand_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("[FAIL] %s sum: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_cout(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("[FAIL] %s cout: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	task automatic read_trace();
		int           fd;
		int           fields;
		int           line_no;
		string        line;
		logic [31:0]  ra;
		logic [31:0]  rb;
		logic [31:0]  rs;
		logic [31:0]  rc;
		logic [31:0]  rg;
		trace_entry_t entry;
		fd = $fopen("verification/cla_adder_trace.txt", "r");
		if (fd == 0) begin
			stop_with_failure("cannot open verification/cla_adder_trace.txt");
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				line_no++;
				if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r") begin
					// comment or blank.
				end else begin
					fields = $sscanf(line, "%h %h %h %h %h", ra, rb, rs, rc, rg);
					if (fields != 5) begin
						stop_with_failure($sformatf("trace line %0d cannot be parsed", line_no));
					end else begin
						entry.a       = ra[cla_cfg_pkg::width-1:0];
						entry.b       = rb[cla_cfg_pkg::width-1:0];
						entry.sum     = rs[cla_cfg_pkg::width-1:0];
						entry.cout    = rc[0];
						entry.gap     = rg[0];
						entry.line_no = line_no;
						trace_q.push_back(entry);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// operands change every cycle even with no strobe.
	task automatic drive_idle();
		logic [31:0] bits_a;
		logic [31:0] bits_b;
		draw_bits(cla_cfg_pkg::width, bits_a);
		draw_bits(cla_cfg_pkg::width, bits_b);
		in_valid <= 1'b0;
		a        <= bits_a[cla_cfg_pkg::width-1:0];
		b        <= bits_b[cla_cfg_pkg::width-1:0];
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			stop_with_failure($sformatf("run went past the limit of %0d cycles", cycle_limit));
		end
	end

	// results come back in strobe order.
	always @(posedge clock) begin : scoreboard
		expect_t head;
		if (rst_n && out_valid) begin
			if (expected_q.size() == 0) begin
				stop_with_failure("out_valid was raised with no addition in flight");
			end else begin
				head = expected_q.pop_front();
				check_sum(head.name, head.sum, sum);
				check_cout(head.name, head.cout, cout);
			end
		end
	end

	initial begin : stimulus
		trace_entry_t entry;
		expect_t      item;
		logic [31:0]  bits;
		clock       = 1'b0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		a           = '0;
		b           = '0;
		cycle_count = 0;
		cycle_limit = 0;
		lfsr_state  = 32'h4f58_4eeb;
		read_trace();
		if (trace_q.size() == 0) begin
			stop_with_failure("trace file holds no additions");
		end else begin
			cycle_limit = reset_cycles + trace_q.size() * 4 + cla_cfg_pkg::latency + 20;
			repeat (reset_cycles) @(posedge clock);
			rst_n <= 1'b1;
			@(posedge clock);
			drive_idle();
			foreach (trace_q[i]) begin
				entry = trace_q[i];
				if (entry.gap) begin
					draw_bits(2, bits); // 0 to 3 idle cycles.
					repeat (bits[1:0]) begin
						@(posedge clock);
						drive_idle();
					end
				end
				@(posedge clock);
				in_valid <= 1'b1;
				a        <= entry.a;
				b        <= entry.b;
				item.sum  = entry.sum;
				item.cout = entry.cout;
				item.name = $sformatf("trace line %0d", entry.line_no);
				expected_q.push_back(item);
			end
			@(posedge clock);
			drive_idle();
			repeat (cla_cfg_pkg::latency + 4) @(posedge clock);
			if (expected_q.size() != 0) begin
				stop_with_failure($sformatf("%0d results never came out", expected_q.size()));
			end else begin
				$display("Test OK");
				$finish;
			end
		end
	end

endmodule

//--- verification/cla_adder_trace.txt
# columns in hex: a b expected_sum expected_cout gap
# gap 1 puts 0 to 3 idle cycles before the line, gap 0 strobes on the next cycle
000000 000000 000000 0 1
ffffff ffffff fffffe 1 1
ffffff 000001 000000 1 1
000001 000001 000002 0 1
555555 aaaaaa ffffff 0 1
555555 555555 aaaaaa 0 1
aaaaaa aaaaaa 555554 1 1
00ffff 000001 010000 0 0
7fffff 000001 800000 0 0
0000ff 000001 000100 0 0
000fff 000001 001000 0 0
00000f 000001 000010 0 0
000003 000001 000004 0 0
800000 800000 000000 1 0
123456 654321 777777 0 0
abcdef 123456 be0245 0 0
fedcba 012346 000000 1 0
0f0f0f f0f0f1 000000 1 0
333333 cccccd 000000 1 0
400000 400000 800000 0 1
c00000 400000 000000 1 1
111111 222222 333333 0 1
999999 666667 000000 1 1
00ff00 000100 010000 0 1
0ffff0 000010 100000 0 1
5a5a5a a5a5a6 000000 1 1
000000 ffffff ffffff 0 0
7fffff 7fffff fffffe 0 0
000080 000080 000100 0 0
008000 008000 010000 0 0
00ffff 00ffff 01fffe 0 0
3c3c3c 3c3c3c 787878 0 0
800001 7fffff 000000 1 0
0a0b0c 010203 0b0d0f 0 1
fffffe 000001 ffffff 0 1
000001 ffffff 000000 1 1

//--- cla_adder.f
src/cla_cfg_pkg.sv
src/prefix_pkg.sv
src/prefix_stage.sv
src/prefix_network.sv
src/operand_delay.sv
src/sum_stage.sv
src/cla_adder.sv
verification/cla_adder_checker.sv
verification/cla_adder_tb.sv
